//--- logic/common.sv
package common;

        // Major opcodes in instruction bits 6:0.
        localparam logic [6:0] LOAD    = 7'b0000011;
        localparam logic [6:0] LOAD_FP = 7'b0000111;
        localparam logic [6:0] OP_IMM  = 7'b0010011;
        localparam logic [6:0] OP      = 7'b0110011;
        localparam logic [6:0] STORE   = 7'b0100011;
        localparam logic [6:0] BRANCH  = 7'b1100011;
        localparam logic [6:0] U_LUI   = 7'b0110111;
        localparam logic [6:0] U_AUIPC = 7'b0010111;
        localparam logic [6:0] JAL     = 7'b1101111;
        localparam logic [6:0] JALR    = 7'b1100111;

        // Base instruction formats; ILLEGAL_TYPE covers every unknown opcode.
        typedef enum logic [2:0] {
                R_TYPE,
                I_TYPE,
                S_TYPE,
                B_TYPE,
                U_TYPE,
                J_TYPE,
                ILLEGAL_TYPE
        } instruction_op_type;

        // Branch conditions carried in funct3 at instruction bits 14:12.
        localparam logic [2:0] BEQ  = 3'b000;
        localparam logic [2:0] BNE  = 3'b001;
        localparam logic [2:0] BLT  = 3'b100; // Signed.
        localparam logic [2:0] BGE  = 3'b101; // Signed.
        localparam logic [2:0] BLTU = 3'b110;
        localparam logic [2:0] BGEU = 3'b111;

endpackage

//--- logic/decode_pkg.sv
package decode_pkg;

        localparam int LANES  = 4;
        localparam int LANE_W = 2;
        localparam int ADDR_W = 8; // APB address width.

        // Register map in byte addresses.
        localparam logic [ADDR_W-1:0] REG_RS1         = 8'h00;
        localparam logic [ADDR_W-1:0] REG_RS2         = 8'h04;
        localparam logic [ADDR_W-1:0] REG_INSTR       = 8'h08;
        localparam logic [ADDR_W-1:0] REG_RESULT_BASE = 8'h10; // Lane k at base plus 4k.

        // Datapath control bits from mem_write in bit 5 down to branch_taken in bit 0.
        typedef struct packed {
                logic mem_write;
                logic mem2reg;
                logic reg_write;
                logic alu_src;
                logic is_branch;
                logic branch_taken;
        } ctrl_word_t;

        typedef struct packed {
                logic        valid;
                logic [31:0] instr;
                logic [31:0] rs1;
                logic [31:0] rs2;
        } lane_req_t;

        typedef struct packed {
                logic                      valid;
                common::instruction_op_type optype;
                ctrl_word_t                ctrl;
        } lane_res_t;

endpackage

//--- logic/control_unit.sv
`timescale 1ns/1ps

module control_unit (
        input  logic [6:0]                 opcode,
        input  common::instruction_op_type optype,
        input  logic [2:0]                 funct3,
        input  logic [31:0]                rs1_data,
        input  logic [31:0]                rs2_data,
        output decode_pkg::ctrl_word_t     ctrl
);

logic eq_flag;
logic lt_flag;
logic ltu_flag;
logic take;

assign eq_flag  = (rs1_data == rs2_data);
assign lt_flag  = ($signed(rs1_data) < $signed(rs2_data));
assign ltu_flag = (rs1_data < rs2_data);

// Greater-or-equal is the complement of less-than in both signed and unsigned forms.
always_comb
begin
        case (funct3)
                common::BEQ:  take = eq_flag;
                common::BNE:  take = !eq_flag;
                common::BLT:  take = lt_flag;
                common::BGE:  take = !lt_flag;
                common::BLTU: take = ltu_flag;
                common::BGEU: take = !ltu_flag;
                default:      take = 1'b0; // Reserved funct3 codes never branch.
        endcase
end

always_comb
begin
        ctrl = '0;
        case (optype)
                common::R_TYPE:
                        ctrl.reg_write = 1'b1;
                common::I_TYPE:
                begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_src   = 1'b1;
                        if (opcode == common::LOAD || opcode == common::LOAD_FP)
                                ctrl.mem2reg = 1'b1;
                end
                common::S_TYPE:
                begin
                        ctrl.alu_src   = 1'b1;
                        ctrl.mem_write = 1'b1;
                end
                common::B_TYPE:
                begin
                        ctrl.is_branch    = 1'b1;
                        ctrl.branch_taken = take;
                end
                common::U_TYPE:
                        if (opcode == common::U_LUI)
                        begin
                                ctrl.reg_write = 1'b1; // AUIPC leaves the word clear.
                                ctrl.alu_src   = 1'b1;
                        end
                common::J_TYPE:
                        ctrl.branch_taken = 1'b1;
                default:
                        ctrl = '0;
        endcase
end

endmodule

//--- logic/decode_lane.sv
`timescale 1ns/1ps

module decode_lane (
        input  logic                  clk,
        input  logic                  rst,
        input  decode_pkg::lane_req_t req,
        output decode_pkg::lane_res_t res
);

logic [6:0]                 opcode;
logic [2:0]                 funct3;
common::instruction_op_type optype;
decode_pkg::ctrl_word_t     ctrl;

assign opcode = req.instr[6:0];
assign funct3 = req.instr[14:12];

always_comb
begin
        case (opcode)
                common::OP:
                        optype = common::R_TYPE;
                common::OP_IMM, common::LOAD, common::LOAD_FP, common::JALR:
                        optype = common::I_TYPE;
                common::STORE:
                        optype = common::S_TYPE;
                common::BRANCH:
                        optype = common::B_TYPE;
                common::U_LUI, common::U_AUIPC:
                        optype = common::U_TYPE;
                common::JAL:
                        optype = common::J_TYPE;
                default:
                        optype = common::ILLEGAL_TYPE;
        endcase
end

control_unit u_control_unit (
        .opcode   (opcode),
        .optype   (optype),
        .funct3   (funct3),
        .rs1_data (req.rs1),
        .rs2_data (req.rs2),
        .ctrl     (ctrl)
);

always_ff @(posedge clk)
begin
        if (rst)
                res.valid <= 1'b0;
        else
        begin
                res.valid <= req.valid;
                if (req.valid)
                begin
                        res.optype <= optype; // Held until the next request.
                        res.ctrl   <= ctrl;
                end
        end
end

endmodule

//--- logic/ctrl_collect.sv
`timescale 1ns/1ps

module ctrl_collect (
        input  logic                                          clk,
        input  logic                                          rst,
        input  decode_pkg::lane_res_t [decode_pkg::LANES-1:0] lane_res,
        input  logic [decode_pkg::LANES-1:0]                  rd_clear,
        output decode_pkg::lane_res_t [decode_pkg::LANES-1:0] results
);

// One slot per lane.  A fresh result replaces whatever is still unread,
// and a read in the same cycle loses to the load.
always_ff @(posedge clk)
begin
        for (int k = 0; k < decode_pkg::LANES; k++)
        begin
                if (rst)
                        results[k].valid <= 1'b0;
                else if (lane_res[k].valid)
                begin
                        results[k].valid  <= 1'b1;
                        results[k].optype <= lane_res[k].optype;
                        results[k].ctrl   <= lane_res[k].ctrl;
                end
                else if (rd_clear[k])
                        results[k].valid <= 1'b0; // Payload stays for debug reads.
        end
end

endmodule

//--- logic/apb_dispatch.sv
`timescale 1ns/1ps

module apb_dispatch (
        input  logic                                          clk,
        input  logic                                          rst,
        input  logic [decode_pkg::ADDR_W-1:0]                 paddr,
        input  logic                                          psel,
        input  logic                                          penable,
        input  logic                                          pwrite,
        input  logic [31:0]                                   pwdata,
        output logic [31:0]                                   prdata,
        output logic                                          pready,
        output logic                                          pslverr,
        input  decode_pkg::lane_res_t [decode_pkg::LANES-1:0] results,
        output decode_pkg::lane_req_t [decode_pkg::LANES-1:0] reqs,
        output logic [decode_pkg::LANES-1:0]                  rd_clear
);

logic [31:0]                   rs1_q;
logic [31:0]                   rs2_q;
logic [decode_pkg::LANE_W-1:0] rr_ptr;
logic [decode_pkg::LANE_W-1:0] res_lane;
logic                          access;
logic                          hit_rs1;
logic                          hit_rs2;
logic                          hit_instr;
logic                          hit_result;
logic                          bad_access;

assign pready  = 1'b1; // No wait states.
assign access  = psel & penable;

assign hit_rs1   = (paddr == decode_pkg::REG_RS1);
assign hit_rs2   = (paddr == decode_pkg::REG_RS2);
assign hit_instr = (paddr == decode_pkg::REG_INSTR);

// Result window is word aligned; the lane index sits just above the byte offset.
assign res_lane   = paddr[decode_pkg::LANE_W+1:2];
assign hit_result = (paddr[decode_pkg::ADDR_W-1:decode_pkg::LANE_W+2] ==
                decode_pkg::REG_RESULT_BASE[decode_pkg::ADDR_W-1:decode_pkg::LANE_W+2]) &&
                (paddr[1:0] == 2'b00);

assign bad_access = !(hit_rs1 || hit_rs2 || hit_instr || hit_result) || (pwrite && hit_result);
assign pslverr    = access & bad_access;

assign rd_clear = (access && !pwrite && hit_result) ?
                ({{(decode_pkg::LANES-1){1'b0}}, 1'b1} << res_lane) : '0;

always_comb
begin
        prdata = '0;
        if (hit_rs1)
                prdata = rs1_q;
        else if (hit_rs2)
                prdata = rs2_q;
        else if (hit_result)
        begin
                prdata[31]  = results[res_lane].valid;
                prdata[8:6] = results[res_lane].optype;
                prdata[5:0] = results[res_lane].ctrl;
        end
end

always_ff @(posedge clk)
begin
        if (access && pwrite && hit_rs1)
                rs1_q <= pwdata;
        if (access && pwrite && hit_rs2)
                rs2_q <= pwdata;
end

always_ff @(posedge clk)
begin
        if (rst)
        begin
                rr_ptr <= '0;
                for (int k = 0; k < decode_pkg::LANES; k++)
                        reqs[k].valid <= 1'b0;
        end
        else
        begin
                for (int k = 0; k < decode_pkg::LANES; k++)
                        reqs[k].valid <= 1'b0; // Requests last a single cycle.
                if (access && pwrite && hit_instr)
                begin
                        reqs[rr_ptr].valid <= 1'b1;
                        reqs[rr_ptr].instr <= pwdata;
                        reqs[rr_ptr].rs1   <= rs1_q;
                        reqs[rr_ptr].rs2   <= rs2_q;
                        rr_ptr             <= rr_ptr + 1'b1; // Wraps after the last lane.
                end
        end
end

endmodule

//--- logic/decode_cluster.sv
`timescale 1ns/1ps

module decode_cluster (
        input  logic                          clk,
        input  logic                          rst,
        input  logic [decode_pkg::ADDR_W-1:0] paddr,
        input  logic                          psel,
        input  logic                          penable,
        input  logic                          pwrite,
        input  logic [31:0]                   pwdata,
        output logic [31:0]                   prdata,
        output logic                          pready,
        output logic                          pslverr
);

decode_pkg::lane_req_t [decode_pkg::LANES-1:0] reqs;
decode_pkg::lane_res_t [decode_pkg::LANES-1:0] lane_res;
decode_pkg::lane_res_t [decode_pkg::LANES-1:0] results;
logic [decode_pkg::LANES-1:0]                  rd_clear;

apb_dispatch u_dispatch (
        .clk      (clk),
        .rst      (rst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .results  (results),
        .reqs     (reqs),
        .rd_clear (rd_clear)
);

for (genvar g = 0; g < decode_pkg::LANES; g++)
begin : lane_gen
        decode_lane u_lane (
                .clk (clk),
                .rst (rst),
                .req (reqs[g]),
                .res (lane_res[g])
        );
end

ctrl_collect u_collect (
        .clk      (clk),
        .rst      (rst),
        .lane_res (lane_res),
        .rd_clear (rd_clear),
        .results  (results)
);

endmodule

//--- testbench/decode_cluster_properties.sv
`timescale 1ns/1ps

module decode_cluster_properties (
        input logic                  clk,
        input logic                  rst,
        input decode_pkg::lane_res_t res
);

// A store never writes the register file.
store_or_write: assert property (@(posedge clk) disable iff (rst)
        res.valid |-> !(res.ctrl.mem_write && res.ctrl.reg_write))
        else $error("Lane result sets mem_write and reg_write together");

taken_needs_jump: assert property (@(posedge clk) disable iff (rst)
        (res.valid && res.ctrl.branch_taken) |->
                (res.ctrl.is_branch || res.optype == common::J_TYPE))
        else $error("Lane result takes a branch that is neither B nor J format");

illegal_is_quiet: assert property (@(posedge clk) disable iff (rst)
        (res.valid && res.optype == common::ILLEGAL_TYPE) |-> (res.ctrl == '0))
        else $error("Illegal opcode produced nonzero control bits");

endmodule

bind decode_lane decode_cluster_properties u_properties (
        .clk (clk),
        .rst (rst),
        .res (res)
);

//--- testbench/decode_cluster_tb.sv
`timescale 1ns/1ps

module decode_cluster_tb;

localparam int POLL_LIMIT      = 20;
localparam int RANDOM_BRANCHES = 8;

logic        clk;
logic        rst;
logic [7:0]  paddr;
logic        psel;
logic        penable;
logic        pwrite;
logic [31:0] pwdata;
logic [31:0] prdata;
logic        pready;
logic        pslverr;

int          errors;
int          checks;
logic [31:0] pending [$]; // Expected result words for the lanes of the open group.

decode_cluster DUT (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
);

initial
begin
        clk = 1'b0;
        forever #4 clk = ~clk;
end

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
                errors++;
                $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        end
endtask

function automatic logic [7:0] result_addr(input int lane);
        return decode_pkg::REG_RESULT_BASE + 8'(lane * 4);
endfunction

// Valid in bit 31, format in bits 8:6 and control bits in 5:0.
function automatic logic [31:0] result_word(input logic [9:0] r);
        return {r[9], 22'b0, r[8:0]};
endfunction

function automatic logic branch_expected(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
                common::BEQ:  return a == b;
                common::BNE:  return a != b;
                common::BLT:  return $signed(a) < $signed(b);
                common::BGE:  return $signed(a) >= $signed(b);
                common::BLTU: return a < b;
                common::BGEU: return a >= b;
                default:      return 1'b0;
        endcase
endfunction

task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
        int waited;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #2; // Response is sampled in the low phase, well away from the edge.
        waited = 0;
        while (!pready && waited < POLL_LIMIT)
        begin
                @(negedge clk);
                #2;
                waited++;
        end
        if (!pready)
        begin
                errors++;
                $display("APB transfer to address %h never saw pready", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata_dropped;
        logic        err;
        apb_access(addr, 1'b1, data, rdata_dropped, err);
        check_value("pslverr", {31'b0, err}, {31'b0, exp_err});
endtask

task automatic apb_read(input logic [7:0] addr, input logic exp_err, output logic [31:0] data);
        logic err;
        apb_access(addr, 1'b0, 32'h0, data, err);
        check_value("pslverr", {31'b0, err}, {31'b0, exp_err});
endtask

task automatic poll_result(input logic [7:0] addr, output logic [31:0] word);
        int tries;
        tries = 0;
        apb_read(addr, 1'b0, word);
        while (!word[31] && tries < POLL_LIMIT)
        begin
                apb_read(addr, 1'b0, word);
                tries++;
        end
        if (!word[31])
        begin
                errors++;
                $display("Result at address %h never became valid", addr);
        end
endtask

// Reads every lane once for its result and once more to see the valid flag gone.
task automatic collect_group();
        logic [31:0] word;
        for (int lane = 0; lane < decode_pkg::LANES; lane++)
        begin
                poll_result(result_addr(lane), word);
                check_value($sformatf("result[%0d]", lane), word, pending[lane]);
                apb_read(result_addr(lane), 1'b0, word);
                check_value($sformatf("result[%0d].valid", lane), {31'b0, word[31]}, 32'h0);
        end
        pending.delete();
endtask

task automatic issue(input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b,
                     input logic [9:0] exp);
        apb_write(decode_pkg::REG_RS1, a, 1'b0);
        apb_write(decode_pkg::REG_RS2, b, 1'b0);
        apb_write(decode_pkg::REG_INSTR, instr, 1'b0);
        pending.push_back(result_word(exp));
        if (pending.size() == decode_pkg::LANES)
                collect_group();
endtask

initial
begin
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v_instr;
        logic [31:0] v_a;
        logic [31:0] v_b;
        logic [31:0] v_exp;
        logic [31:0] bb_instr [4];
        logic [9:0]  bb_exp [4];
        logic [2:0]  codes [6];
        logic [2:0]  f3;
        int          fd;
        int          loaded;
        errors     = 0;
        checks     = 0;
        loaded     = 0;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        void'($urandom(39));
        codes = '{common::BEQ, common::BNE, common::BLT, common::BGE, common::BLTU, common::BGEU};
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int lane = 0; lane < decode_pkg::LANES; lane++)
        begin
                apb_read(result_addr(lane), 1'b0, word);
                check_value("reset result valid", {31'b0, word[31]}, 32'h0);
        end

        apb_write(decode_pkg::REG_RS1, 32'hA5A5_0F0F, 1'b0);
        apb_write(decode_pkg::REG_RS2, 32'h1234_5678, 1'b0);
        apb_write(8'h0C, 32'hFFFF_FFFF, 1'b1);
        apb_read(8'h40, 1'b1, word);
        apb_read(decode_pkg::REG_RS1, 1'b0, word);
        check_value("rs1", word, 32'hA5A5_0F0F);
        apb_read(decode_pkg::REG_RS2, 1'b0, word);
        check_value("rs2", word, 32'h1234_5678);
        for (int lane = 0; lane < decode_pkg::LANES; lane++)
        begin
                apb_read(result_addr(lane), 1'b0, word); // A bad write must not issue.
                check_value("result valid", {31'b0, word[31]}, 32'h0);
        end

        fd = $fopen("testbench/decode_vectors.txt", "r");
        if (fd == 0)
        begin
                errors++;
                $display("Cannot open testbench/decode_vectors.txt");
        end
        else
        begin
                while ($fscanf(fd, "%h %h %h %h", v_instr, v_a, v_b, v_exp) == 4)
                begin
                        issue(v_instr, v_a, v_b, v_exp[9:0]);
                        loaded++;
                end
                $fclose(fd);
        end
        if (loaded == 0 || pending.size() != 0)
        begin
                errors++;
                $display("Vector file held %0d vectors, not a whole number of lane groups", loaded);
        end

        // Four instruction writes in a row; lane k should hold the k-th result.
        bb_instr = '{32'h003100B3, 32'h0020A023, 32'h123450B7, 32'h00208063};
        bb_exp   = '{10'h208, 10'h2A4, 10'h30C, 10'h2C3};
        pending.delete();
        apb_write(decode_pkg::REG_RS1, 32'h0000_0010, 1'b0);
        apb_write(decode_pkg::REG_RS2, 32'h0000_0010, 1'b0);
        for (int k = 0; k < 4; k++)
        begin
                apb_write(decode_pkg::REG_INSTR, bb_instr[k], 1'b0);
                pending.push_back(result_word(bb_exp[k]));
        end
        // A write to a result address is refused and leaves the lane 1 result valid.
        apb_write(result_addr(1), 32'hFFFF_FFFF, 1'b1);
        collect_group();

        for (int n = 0; n < RANDOM_BRANCHES; n++)
        begin
                f3 = codes[$urandom % 6];
                a  = $urandom;
                if (n % 3 == 0)
                        b = a;
                else if (n % 3 == 1)
                        b = a ^ 32'h8000_0000; // Top bit differs, so signed and unsigned split.
                else
                        b = $urandom;
                // Valid, B format and is_branch give 0x2C2; bit 0 is the outcome.
                issue(32'h0020_8063 | {17'b0, f3, 12'b0}, a, b,
                      10'h2C2 | {9'b0, branch_expected(f3, a, b)});
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
                $display("Verification passed");
        else
                $display("Verification failed");
        $finish;
end

endmodule

//--- testbench/decode_vectors.txt
003100B3 00000003 00000004 208
00500093 00000010 00000000 24C
0000A103 00001000 00000000 25C
0000A007 00001000 00000000 25C
0020A023 00001000 0000BEEF 2A4
123450B7 00000000 00000000 30C
00001097 00000000 00000000 300
0080006F 00000000 00000000 341
000080E7 00002000 00000000 24C
0000007F 00000000 00000000 380
00208063 00000005 00000005 2C3
00208063 00000005 00000006 2C2
00209063 00000005 00000006 2C3
00209063 00000007 00000007 2C2
0020C063 FFFFFFFF 00000001 2C3
0020E063 FFFFFFFF 00000001 2C2
0020D063 00000001 FFFFFFFF 2C3
0020F063 00000001 FFFFFFFF 2C2
0020D063 80000000 80000000 2C3
0020E063 7FFFFFFF 80000000 2C3

//--- verilog.f
logic/common.sv
logic/decode_pkg.sv
logic/control_unit.sv
logic/decode_lane.sv
logic/ctrl_collect.sv
logic/apb_dispatch.sv
logic/decode_cluster.sv
testbench/decode_cluster_properties.sv
testbench/decode_cluster_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir
TOP      = decode_cluster_tb
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /Verification passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
